// ==== Makefile ====
# Verilator build and run for the block cost testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_block_cost
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf $(OBJ_DIR)

// ==== files.f ====
verilog/me_cost_pkg.sv
verilog/square_table.sv
verilog/sse_accum.sv
verilog/sad_accum.sv
verilog/cost_combine.sv
verilog/block_cost_top.sv
testbench/tb_clock_gen.sv
testbench/block_cost_properties.sv
testbench/tb_block_cost.sv

// ==== testbench/block_cost_properties.sv ====
// Handshake properties for block_cost_top; checked only while rst_n is high
`timescale 1ns/1ps
`default_nettype none

module block_cost_properties (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   in_ready,
    input logic                   res_valid,
    input logic                   res_ready,
    input me_cost_pkg::cand_idx_t best_index,
    input me_cost_pkg::cost_t     best_cost,
    input me_cost_pkg::sse_t      best_sse,
    input me_cost_pkg::sad_t      best_sad
);

    // ------------------------------
    // Result stream
    // ------------------------------
    property result_held;
        @(posedge clk) disable iff (!rst_n)
        (res_valid && !res_ready) |=> (res_valid && $stable(best_index)
            && $stable(best_cost) && $stable(best_sse) && $stable(best_sad));
    endproperty

    a_result_held: assert property (result_held)
        else $error("result changed or dropped before it was taken");

    // Input stalls for as long as a result waits
    a_stall: assert property (@(posedge clk) disable iff (!rst_n) res_valid |-> !in_ready)
        else $error("in_ready high while res_valid is high");

    a_known: assert property (@(posedge clk) rst_n |-> !$isunknown(res_valid))
        else $error("res_valid unknown after reset");

endmodule

bind block_cost_top block_cost_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_ready   (in_ready),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .best_index (best_index),
    .best_cost  (best_cost),
    .best_sse   (best_sse),
    .best_sad   (best_sad)
);

`default_nettype wire

// ==== testbench/tb_block_cost.sv ====
// Runs BLOCK_SIZE 8 and LAMBDA_SHIFT 2 only; groups hold up to 6 candidates of up to 8 rows
`timescale 1ns/1ps
`default_nettype none

module tb_block_cost;
    import me_cost_pkg::*;

    localparam int BLOCK_SIZE   = 8;
    localparam int LAMBDA_SHIFT = 2;
    localparam int ROW_W        = BLOCK_SIZE * PIX_W;
    localparam int MAX_CANDS    = 6;
    localparam int MAX_ROWS     = 8;
    localparam int LATENCY      = 4;
    localparam int TIMEOUT      = 200;

    typedef logic [ROW_W-1:0] row_t;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    logic      in_ready;
    row_t      cur_row;
    row_t      ref_row;
    logic      row_last;
    logic      group_last;
    logic      res_valid;
    logic      res_ready;
    cand_idx_t best_index;
    cost_t     best_cost;
    sse_t      best_sse;
    sad_t      best_sad;

    // Group under test
    row_t      cur_mem [MAX_CANDS][MAX_ROWS];
    row_t      ref_mem [MAX_CANDS][MAX_ROWS];
    int        row_cnt [MAX_CANDS];
    int        cand_cnt;

    // Model results
    cand_idx_t exp_index;
    cost_t     exp_cost;
    sse_t      exp_sse;
    sad_t      exp_sad;

    int        cycle = 0;
    int        last_accept;
    int        error_count;
    bit        run_over;

    tb_clock_gen u_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    block_cost_top #(
        .BLOCK_SIZE   (BLOCK_SIZE),
        .LAMBDA_SHIFT (LAMBDA_SHIFT)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .cur_row    (cur_row),
        .ref_row    (ref_row),
        .row_last   (row_last),
        .group_last (group_last),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .best_index (best_index),
        .best_cost  (best_cost),
        .best_sse   (best_sse),
        .best_sad   (best_sad)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ------------------------------
    // Error handling and compares
    // ------------------------------
    task automatic stop_on_error();
        error_count++;
        run_over = 1'b1;
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_index(input string name, input cand_idx_t got, input cand_idx_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_cost(input string name, input cost_t got, input cost_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sse(input string name, input sse_t got, input sse_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_sad(input string name, input sad_t got, input sad_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_result();
        check_index("best_index", best_index, exp_index);
        check_cost("best_cost", best_cost, exp_cost);
        check_sse("best_sse", best_sse, exp_sse);
        check_sad("best_sad", best_sad, exp_sad);
    endtask

    // ------------------------------
    // Stimulus builders
    // ------------------------------
    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($urandom % 32'(hi - lo + 1));
    endfunction

    function automatic row_t random_row();
        row_t r;
        for (int l = 0; l < BLOCK_SIZE; l++) begin
            r[l*PIX_W +: PIX_W] = pix_t'($urandom);
        end
        return r;
    endfunction

    task automatic fill_random(input int c);
        row_cnt[c] = rand_range(1, MAX_ROWS);
        for (int r = 0; r < row_cnt[c]; r++) begin
            cur_mem[c][r] = random_row();
            ref_mem[c][r] = random_row();
        end
    endtask

    task automatic build_random_group();
        cand_cnt = rand_range(1, MAX_CANDS);
        for (int c = 0; c < cand_cnt; c++) begin
            fill_random(c);
        end
    endtask

    // Close match copied into several slots, so the best cost is tied
    task automatic build_tie_group();
        row_t tmpl_cur [MAX_ROWS];
        row_t tmpl_ref [MAX_ROWS];
        row_t flips;
        int   nr;
        int   first;
        cand_cnt = rand_range(3, MAX_CANDS);
        for (int c = 0; c < cand_cnt; c++) begin
            fill_random(c);
        end
        nr = rand_range(1, MAX_ROWS);
        for (int r = 0; r < nr; r++) begin
            flips = '0;
            for (int l = 0; l < BLOCK_SIZE; l++) begin
                flips[l*PIX_W] = $urandom % 2 == 1;
            end
            tmpl_cur[r] = random_row();
            tmpl_ref[r] = tmpl_cur[r] ^ flips;
        end
        first = rand_range(0, cand_cnt - 2);
        for (int c = first; c < cand_cnt; c++) begin
            if (c == first || c == cand_cnt - 1 || $urandom % 2 == 1) begin
                row_cnt[c] = nr;
                for (int r = 0; r < nr; r++) begin
                    cur_mem[c][r] = tmpl_cur[r];
                    ref_mem[c][r] = tmpl_ref[r];
                end
            end
        end
    endtask

    // All 0 against all 255 in both directions, full block
    task automatic build_extreme_group();
        cand_cnt = 2;
        for (int c = 0; c < 2; c++) begin
            row_cnt[c] = MAX_ROWS;
            for (int r = 0; r < MAX_ROWS; r++) begin
                cur_mem[c][r] = (c == 0) ? '0 : '1;
                ref_mem[c][r] = (c == 0) ? '1 : '0;
            end
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    task automatic compute_model();
        longint sse;
        longint sad;
        longint cost;
        longint best;
        longint a;
        longint b;
        longint d;
        best = 0;
        for (int c = 0; c < cand_cnt; c++) begin
            sse = 0;
            sad = 0;
            for (int r = 0; r < row_cnt[c]; r++) begin
                for (int l = 0; l < BLOCK_SIZE; l++) begin
                    a = longint'(cur_mem[c][r][l*PIX_W +: PIX_W]);
                    b = longint'(ref_mem[c][r][l*PIX_W +: PIX_W]);
                    d = (a > b) ? a - b : b - a;
                    sse = sse + d * d;
                    sad = sad + d;
                end
            end
            cost = sse + (sad << LAMBDA_SHIFT);
            // Ties keep the lower index
            if (c == 0 || cost < best) begin
                best      = cost;
                exp_index = cand_idx_t'(c);
                exp_cost  = cost_t'(cost);
                exp_sse   = sse_t'(sse);
                exp_sad   = sad_t'(sad);
            end
        end
    endtask

    // ------------------------------
    // Bus drivers
    // ------------------------------
    // Entered 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send_row(input row_t cur_data, input row_t ref_data,
                            input logic rl, input logic gl);
        int waited;
        waited     = 0;
        in_valid   = 1'b1;
        cur_row    = cur_data;
        ref_row    = ref_data;
        row_last   = rl;
        group_last = gl;
        while (!in_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: in_ready stayed low for %0d cycles", TIMEOUT);
                stop_on_error();
            end
        end
        @(posedge clk);
        #1;
        last_accept = cycle;
        in_valid    = 1'b0;
        row_last    = 1'b0;
        group_last  = 1'b0;
    endtask

    task automatic send_group();
        int last_row;
        for (int c = 0; c < cand_cnt; c++) begin
            last_row = row_cnt[c] - 1;
            for (int r = 0; r <= last_row; r++) begin
                if ($urandom % 4 == 0) begin
                    @(posedge clk);
                    #1;
                end
                send_row(cur_mem[c][r], ref_mem[c][r], r == last_row,
                         (c == cand_cnt - 1) && (r == last_row));
            end
        end
    endtask

    // Waits for the result, holds it back for a random spell, then takes it
    task automatic collect_result();
        int waited;
        int spell;
        waited = 0;
        while (!res_valid) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: no result within %0d cycles of the last row", TIMEOUT);
                stop_on_error();
            end
        end
        check_latency("res_valid latency", cycle - last_accept, LATENCY);
        spell = rand_range(0, 5);
        repeat (spell) begin
            check_result();
            check_flag("in_ready", in_ready, 1'b0);
            @(posedge clk);
            #1;
            check_flag("res_valid", res_valid, 1'b1);
        end
        check_result();
        res_ready = 1'b1;
        @(posedge clk);
        #1;
        res_ready = 1'b0;
        check_flag("res_valid", res_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);
    endtask

    task automatic run_group();
        compute_model();
        send_group();
        collect_result();
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        int waited;
        void'($urandom(96));
        in_valid    = 1'b0;
        cur_row     = '0;
        ref_row     = '0;
        row_last    = 1'b0;
        group_last  = 1'b0;
        res_ready   = 1'b0;
        error_count = 0;
        run_over    = 1'b0;
        waited      = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                $display("timeout: reset was never released");
                stop_on_error();
            end
        end
        @(posedge clk);
        #1;
        check_flag("res_valid", res_valid, 1'b0);
        check_flag("in_ready", in_ready, 1'b1);

        for (int g = 0; g < 40; g++) begin
            build_random_group();
            run_group();
        end
        for (int g = 0; g < 12; g++) begin
            build_tie_group();
            run_group();
        end
        build_extreme_group();
        run_group();
        // Normal traffic again after the corner cases
        for (int g = 0; g < 10; g++) begin
            build_random_group();
            run_group();
        end

        run_over = 1'b1;
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "run ended with errors");
        end
    end

    // Catches a run stopped from elsewhere, such as a failed assertion
    final begin
        if (!run_over) begin
            $display("Done: errors found");
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// Free-running 8 ns clock; rst_n is released 1 ns after the fifth rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

    always #4 clk = ~clk;

endmodule

`default_nettype wire

// ==== verilog/block_cost_top.sv ====
// Result follows the last row of a group by 4 cycles; input stalls until that result is taken
`timescale 1ns/1ps
`default_nettype none

module block_cost_top #(
    parameter int BLOCK_SIZE   = 8,
    parameter int LAMBDA_SHIFT = 2
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    output logic                                    in_ready,
    input  logic [BLOCK_SIZE*me_cost_pkg::PIX_W-1:0] cur_row,
    input  logic [BLOCK_SIZE*me_cost_pkg::PIX_W-1:0] ref_row,
    input  logic                                    row_last,
    input  logic                                    group_last,
    output logic                                    res_valid,
    input  logic                                    res_ready,
    output me_cost_pkg::cand_idx_t                  best_index,
    output me_cost_pkg::cost_t                      best_cost,
    output me_cost_pkg::sse_t                       best_sse,
    output me_cost_pkg::sad_t                       best_sad
);
    import me_cost_pkg::*;

    logic sse_done;
    logic sad_done;
    sse_t sse_value;
    sad_t sad_value;

    // ------------------------------
    // Accumulators side by side
    // ------------------------------
    sse_accum #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_sse (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .cur_row   (cur_row),
        .ref_row   (ref_row),
        .row_last  (row_last),
        .sse_done  (sse_done),
        .sse_value (sse_value)
    );

    sad_accum #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_sad (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .cur_row   (cur_row),
        .ref_row   (ref_row),
        .row_last  (row_last),
        .sad_done  (sad_done),
        .sad_value (sad_value)
    );

    // Cost, group best and flow control
    cost_combine #(
        .LAMBDA_SHIFT (LAMBDA_SHIFT)
    ) u_combine (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .group_last (group_last),
        .in_ready   (in_ready),
        .sad_done   (sad_done),
        .sad_value  (sad_value),
        .sse_done   (sse_done),
        .sse_value  (sse_value),
        .res_valid  (res_valid),
        .res_ready  (res_ready),
        .best_index (best_index),
        .best_cost  (best_cost),
        .best_sse   (best_sse),
        .best_sad   (best_sad)
    );

endmodule

`default_nettype wire

// ==== verilog/cost_combine.sv ====
// Expects sad_done exactly one cycle before sse_done of the same candidate; one group end in flight
`timescale 1ns/1ps
`default_nettype none

module cost_combine #(
    parameter int LAMBDA_SHIFT = 2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic                   group_last,
    output logic                   in_ready,
    input  logic                   sad_done,
    input  me_cost_pkg::sad_t      sad_value,
    input  logic                   sse_done,
    input  me_cost_pkg::sse_t      sse_value,
    output logic                   res_valid,
    input  logic                   res_ready,
    output me_cost_pkg::cand_idx_t best_index,
    output me_cost_pkg::cost_t     best_cost,
    output me_cost_pkg::sse_t      best_sse,
    output me_cost_pkg::sad_t      best_sad
);
    import me_cost_pkg::*;

    logic      stall_q;
    logic      have_best_q;
    logic [3:0] gl_pipe_q;
    sad_t      sad_hold_q;
    cand_idx_t cand_cnt_q;
    cost_t     cand_cost;
    logic      take_cand;
    logic      group_accept;
    logic      res_accept;

    assign in_ready     = ~stall_q;
    assign group_accept = in_valid & in_ready & group_last;
    assign res_accept   = res_valid & res_ready;

    // Strictly lower cost wins, so ties keep the earlier index
    assign cand_cost = cost_t'(sse_value) + (cost_t'(sad_hold_q) << LAMBDA_SHIFT);
    assign take_cand = sse_done & (~have_best_q | (cand_cost < best_cost));

    // SAD arrives a cycle ahead of SSE
    always_ff @(posedge clk) begin
        if (sad_done) begin
            sad_hold_q <= sad_value;
        end
    end

    // ------------------------------
    // Group control and handshake
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_q     <= 1'b0;
            gl_pipe_q   <= '0;
            res_valid   <= 1'b0;
            cand_cnt_q  <= '0;
            have_best_q <= 1'b0;
        end else begin
            // Group end comes out of the 4 stages just after its last best update
            gl_pipe_q <= {gl_pipe_q[2:0], group_accept};
            if (group_accept) begin
                stall_q <= 1'b1;
            end else if (res_accept) begin
                stall_q <= 1'b0;
            end
            if (gl_pipe_q[3]) begin
                res_valid <= 1'b1;
            end else if (res_accept) begin
                res_valid <= 1'b0;
            end
            if (res_accept) begin
                cand_cnt_q  <= '0;
                have_best_q <= 1'b0;
            end else if (sse_done) begin
                cand_cnt_q  <= cand_cnt_q + 1'b1;
                have_best_q <= 1'b1;
            end
        end
    end

    // Best candidate so far
    always_ff @(posedge clk) begin
        if (take_cand) begin
            best_index <= cand_cnt_q;
            best_cost  <= cand_cost;
            best_sse   <= sse_value;
            best_sad   <= sad_hold_q;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/me_cost_pkg.sv ====
// Shared pixel and cost widths. PIX_W stays 8 because the square table holds 256 entries
`default_nettype none

package me_cost_pkg;

    // ------------------------------
    // Pixel and result widths
    // ------------------------------
    localparam int PIX_W = 8;

    typedef logic [PIX_W-1:0] pix_t;

    // Square of a pixel difference
    typedef logic [15:0] sq_t;

    // Per-candidate sums
    typedef logic [31:0] sse_t;
    typedef logic [23:0] sad_t;

    // SSE plus weighted SAD
    typedef logic [39:0] cost_t;

    // Index of a candidate within a group, up to 256
    typedef logic [7:0] cand_idx_t;

    // ------------------------------
    // Helpers
    // ------------------------------
    // Absolute difference of two pixels, always fits a pixel
    function automatic pix_t abs_diff(input pix_t a, input pix_t b);
        pix_t d;
        if (a > b) begin
            d = a - b;
        end else begin
            d = b - a;
        end
        return d;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/sad_accum.sv ====
// SAD per candidate; sad_done comes 2 cycles after the accepted last row, total wraps at 24 bits
`timescale 1ns/1ps
`default_nettype none

module sad_accum #(
    parameter int BLOCK_SIZE = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    input  logic                                    in_ready,
    input  logic [BLOCK_SIZE*me_cost_pkg::PIX_W-1:0] cur_row,
    input  logic [BLOCK_SIZE*me_cost_pkg::PIX_W-1:0] ref_row,
    input  logic                                    row_last,
    output logic                                    sad_done,
    output me_cost_pkg::sad_t                       sad_value
);
    import me_cost_pkg::*;

    logic accept;
    pix_t diff_q [BLOCK_SIZE];
    logic valid_q, last_q;
    sad_t total_q;
    sad_t row_sum;
    sad_t next_total;

    assign accept = in_valid & in_ready;

    // Stage 1: lane differences
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < BLOCK_SIZE; i++) begin
                diff_q[i] <= abs_diff(cur_row[i*PIX_W +: PIX_W], ref_row[i*PIX_W +: PIX_W]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else begin
            valid_q <= accept;
            last_q  <= accept & row_last;
        end
    end

    // Stage 2: add the row into the running total
    always_comb begin
        row_sum = '0;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            row_sum = row_sum + sad_t'(diff_q[i]);
        end
        next_total = total_q + row_sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total_q  <= '0;
            sad_done <= 1'b0;
        end else begin
            sad_done <= valid_q & last_q;
            if (valid_q) begin
                total_q <= last_q ? '0 : next_total;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid_q && last_q) begin
            sad_value <= next_total;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/square_table.sv ====
// Read-only square table for 0..255, one cycle latency, output holds while en is low
`timescale 1ns/1ps
`default_nettype none

module square_table (
    input  logic               clk,
    input  logic               en,
    input  me_cost_pkg::pix_t  addr,
    output me_cost_pkg::sq_t   square
);
    import me_cost_pkg::*;

    localparam int DEPTH = 2 ** PIX_W;

    typedef logic [DEPTH-1:0][15:0] sq_table_t;

    // Filled once at elaboration
    function automatic sq_table_t build_squares();
        sq_table_t t;
        for (int i = 0; i < DEPTH; i++) begin
            t[i] = sq_t'(i * i);
        end
        return t;
    endfunction

    localparam sq_table_t SQUARES = build_squares();

    // Synchronous read, like a block ROM
    always_ff @(posedge clk) begin
        if (en) begin
            square <= SQUARES[addr];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sse_accum.sv ====
// SSE per candidate; sse_done comes 3 cycles after the accepted last row, total wraps at 32 bits
`timescale 1ns/1ps
`default_nettype none

module sse_accum #(
    parameter int BLOCK_SIZE = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    in_valid,
    input  logic                                    in_ready,
    input  logic [BLOCK_SIZE*me_cost_pkg::PIX_W-1:0] cur_row,
    input  logic [BLOCK_SIZE*me_cost_pkg::PIX_W-1:0] ref_row,
    input  logic                                    row_last,
    output logic                                    sse_done,
    output me_cost_pkg::sse_t                       sse_value
);
    import me_cost_pkg::*;

    logic accept;
    pix_t diff_q [BLOCK_SIZE];
    sq_t  sq     [BLOCK_SIZE];
    logic valid1_q, last1_q;
    logic valid2_q, last2_q;
    sse_t total_q;
    sse_t row_sum;
    sse_t next_total;

    assign accept = in_valid & in_ready;

    // ------------------------------
    // Stage 1: lane differences
    // ------------------------------
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < BLOCK_SIZE; i++) begin
                diff_q[i] <= abs_diff(cur_row[i*PIX_W +: PIX_W], ref_row[i*PIX_W +: PIX_W]);
            end
        end
    end

    // Stage 2: one square lookup per lane
    for (genvar g = 0; g < BLOCK_SIZE; g++) begin : g_lane
        square_table u_square (
            .clk    (clk),
            .en     (valid1_q),
            .addr   (diff_q[g]),
            .square (sq[g])
        );
    end

    // Row flags follow the data through both stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid1_q <= 1'b0;
            last1_q  <= 1'b0;
            valid2_q <= 1'b0;
            last2_q  <= 1'b0;
        end else begin
            valid1_q <= accept;
            last1_q  <= accept & row_last;
            valid2_q <= valid1_q;
            last2_q  <= last1_q;
        end
    end

    // ------------------------------
    // Stage 3: running total
    // ------------------------------
    always_comb begin
        row_sum = '0;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            row_sum = row_sum + sse_t'(sq[i]);
        end
        next_total = total_q + row_sum;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            total_q  <= '0;
            sse_done <= 1'b0;
        end else begin
            sse_done <= valid2_q & last2_q;
            if (valid2_q) begin
                // Restart for the next candidate
                total_q <= last2_q ? '0 : next_total;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (valid2_q && last2_q) begin
            sse_value <= next_total;
        end
    end

endmodule

`default_nettype wire
